//--- src/erx_params.svh
`ifndef ERX_PARAMS_SVH
`define ERX_PARAMS_SVH

// queue slots, also the credits the transmitter holds after reset
`define ERX_QUEUE_DEPTH 4

// consumer credit and fill counters
`define ERX_CREDIT_W 3

// 16-bit lane words per transaction
`define ERX_HALFWORDS 7

`endif

//--- src/erx_pkg.sv
`include "erx_params.svh"

package erx_pkg;

   // one rx_lclk cycle of the byte lane
   typedef struct packed
   {
      logic [1:0]  frame;   // [0] first edge, [1] second edge
      logic [15:0] word;    // low byte sampled on the first edge
   } erx_lane_t;

   // emesh style packet, access in bit 0
   typedef struct packed
   {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
   } erx_packet_t;

   // record handed to the consumer
   typedef struct packed
   {
      logic        burst;   // frame still high after halfword 6
      erx_packet_t packet;
   } erx_rx_t;

   // assembly buffer
   // written per halfword, read back as wire bytes
   typedef union packed
   {
      logic [`ERX_HALFWORDS-1:0][15:0]  hw;      // hw[k] = bytes 2k, 2k+1
      logic [2*`ERX_HALFWORDS-1:0][7:0] bytes;   // bytes[n] = bits 8n+7:8n
   } erx_sample_u;

endpackage

//--- src/erx_lane_sampler.sv
`timescale 1ns/1ps

module erx_lane_sampler
(
   input  logic               rx_lclk,
   input  logic               rst_n,
   input  erx_pkg::erx_lane_t lane,    // word + frame pair from the pins
   output erx_pkg::erx_lane_t lane_q,  // registered copy
   output logic               frame_start
);

   //############################################################
   // input capture
   //############################################################

   // stands in for the ddr input cells
   // both edges arrive together as one 16-bit word
   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         lane_q <= '0;               // frame low after reset
      end
      else
      begin
         lane_q <= lane;             // one cycle lane to lane_q
      end
   end

   //############################################################
   // frame edge
   //############################################################

   // first edge low, second edge high
   // the frame rose inside this cycle, so a new transaction
   // begins with this word as halfword 0
   assign frame_start = lane_q.frame[1] & ~lane_q.frame[0];

   // frame level for the assembler is lane_q.frame[1]
   // a burst keeps both samples high, so no start is flagged

endmodule

//--- src/erx_packet_assembler.sv
`timescale 1ns/1ps
`include "erx_params.svh"

module erx_packet_assembler
(
   input  logic               rx_lclk,
   input  logic               rst_n,
   input  erx_pkg::erx_lane_t lane_q,
   input  logic               frame_start,
   output logic               pkt_valid,    // 2 cycles after halfword 6
   output erx_pkg::erx_rx_t   pkt
);

   localparam logic [`ERX_HALFWORDS-1:0] ptr_first = `ERX_HALFWORDS'(1'b1);
   localparam logic [`ERX_HALFWORDS-1:0] ptr_burst = `ERX_HALFWORDS'(4'b1000);

   logic                      frame;     // second edge frame level
   logic [`ERX_HALFWORDS-1:0] ptr;       // one-hot halfword pointer
   logic [`ERX_HALFWORDS-1:0] ptr_eff;   // pointer used this cycle
   erx_pkg::erx_sample_u      sample;    // 112-bit assembly buffer
   logic                      access;    // sample complete

   assign frame = lane_q.frame[1];

   // a fresh frame always lands on halfword 0
   // covers a new packet right behind halfword 6
   assign ptr_eff = frame_start ? ptr_first : ptr;

   //############################################################
   // halfword pointer
   //############################################################

   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
         ptr <= ptr_first;
      else if (!frame)
         ptr <= ptr_first;                      // idle, wait for frame
      else if (ptr_eff[`ERX_HALFWORDS-1])
         ptr <= ptr_burst;                      // anticipate burst
      else
         ptr <= ptr_eff << 1;                   // middle of frame
   end

   // halfword write, burst only refreshes 3 to 6
   always_ff @(posedge rx_lclk)
   begin
      for (int k = 0; k < `ERX_HALFWORDS; k++)
      begin
         if (frame && ptr_eff[k])
            sample.hw[k] <= lane_q.word;
      end
   end

   //############################################################
   // valid pipeline
   //############################################################

   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         access    <= 1'b0;
         pkt_valid <= 1'b0;
      end
      else
      begin
         access    <= frame & ptr_eff[`ERX_HALFWORDS-1];  // last halfword seen
         pkt_valid <= access;                             // lines up with pkt
      end
   end

   //############################################################
   // byte shuffle
   //############################################################

   always_ff @(posedge rx_lclk)
   begin
      if (access)
      begin
         pkt.burst <= frame & ~frame_start;     // frame held past halfword 6
         pkt.packet.access   <= sample.bytes[5][0];
         pkt.packet.write    <= sample.bytes[5][1];
         pkt.packet.datamode <= sample.bytes[5][3:2];
         pkt.packet.ctrlmode <= sample.bytes[1][7:4];
         pkt.packet.dstaddr  <= {sample.bytes[1][3:0],
                                 sample.bytes[2],
                                 sample.bytes[3],
                                 sample.bytes[4],
                                 sample.bytes[5][7:4]};
         pkt.packet.data     <= {sample.bytes[6], sample.bytes[7],
                                 sample.bytes[8], sample.bytes[9]};    // msb first
         pkt.packet.srcaddr  <= {sample.bytes[10], sample.bytes[11],
                                 sample.bytes[12], sample.bytes[13]};
      end
   end

   // new frame only on an idle pointer or right after halfword 6
   a_frame_start_aligned : assert property (@(posedge rx_lclk) disable iff (!rst_n)
      frame_start |-> (ptr[0] || access));

endmodule

//--- src/erx_credit_queue.sv
`timescale 1ns/1ps
`include "erx_params.svh"

module erx_credit_queue
(
   input  logic             rx_lclk,
   input  logic             rst_n,
   input  logic             pkt_valid,
   input  erx_pkg::erx_rx_t pkt,
   input  logic             out_credit,    // consumer grants one delivery
   output logic             link_credit,   // one slot freed
   output logic             out_valid,
   output erx_pkg::erx_rx_t out_rx
);

   localparam int ptr_w = $clog2(`ERX_QUEUE_DEPTH);

   erx_pkg::erx_rx_t          mem [`ERX_QUEUE_DEPTH];
   logic [ptr_w-1:0]          wr_ptr;
   logic [ptr_w-1:0]          rd_ptr;
   logic [`ERX_CREDIT_W-1:0]  count;          // filled slots
   logic [`ERX_CREDIT_W-1:0]  cons_credit;    // deliveries allowed
   logic                      empty;
   logic                      pop;
   logic                      bypass;         // incoming record goes straight out
   logic                      store;
   logic                      take;

   //############################################################
   // pop decision
   //############################################################

   assign empty  = (count == '0);
   assign pop    = (!empty || pkt_valid) && (cons_credit != '0);
   assign bypass = pop && empty;
   assign store  = pkt_valid && !bypass;
   assign take   = pop && !empty;

   assign link_credit = pop;                  // same cycle as the pop

   //############################################################
   // storage
   //############################################################

   always_ff @(posedge rx_lclk)
   begin
      if (store)
         mem[wr_ptr] <= pkt;
   end

   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (store)
            wr_ptr <= (wr_ptr == ptr_w'(`ERX_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (take)
            rd_ptr <= (rd_ptr == ptr_w'(`ERX_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   // fill level and consumer credits
   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
      begin
         count       <= '0;
         cons_credit <= '0;
      end
      else
      begin
         case ({store, take})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         case ({out_credit, pop})
            2'b10:   cons_credit <= cons_credit + 1'b1;
            2'b01:   cons_credit <= cons_credit - 1'b1;
            default: cons_credit <= cons_credit;
         endcase
      end
   end

   //############################################################
   // delivery
   //############################################################

   always_ff @(posedge rx_lclk)
   begin
      if (!rst_n)
         out_valid <= 1'b0;
      else
         out_valid <= pop;
   end

   always_ff @(posedge rx_lclk)
   begin
      if (pop)
         out_rx <= bypass ? pkt : mem[rd_ptr];    // empty queue skips storage
   end

   // transmitter never sends without a credit
   a_no_overflow : assert property (@(posedge rx_lclk) disable iff (!rst_n)
      pkt_valid |-> (count != `ERX_CREDIT_W'(`ERX_QUEUE_DEPTH)));

   // consumer keeps its grants within the counter
   a_credit_range : assert property (@(posedge rx_lclk) disable iff (!rst_n)
      (out_credit && !pop) |-> (cons_credit != '1));

endmodule

//--- src/erx_io.sv
`timescale 1ns/1ps

module erx_io
(
   input  logic               rx_lclk,
   input  logic               rst_n,
   input  erx_pkg::erx_lane_t lane,          // from the transmitter
   input  logic               out_credit,    // consumer credit pulse
   output logic               link_credit,   // back to the transmitter
   output logic               out_valid,
   output erx_pkg::erx_rx_t   out_rx
);

   erx_pkg::erx_lane_t lane_q;        // registered lane word
   logic               frame_start;   // new transaction
   logic               pkt_valid;
   erx_pkg::erx_rx_t   pkt;           // decoded packet + burst

   //############################################################
   // front end
   //############################################################

   erx_lane_sampler u_sampler
   (
      .rx_lclk     (rx_lclk),
      .rst_n       (rst_n),
      .lane        (lane),
      .lane_q      (lane_q),
      .frame_start (frame_start)
   );

   // 7 halfwords into one packet
   erx_packet_assembler u_assembler
   (
      .rx_lclk     (rx_lclk),
      .rst_n       (rst_n),
      .lane_q      (lane_q),
      .frame_start (frame_start),
      .pkt_valid   (pkt_valid),
      .pkt         (pkt)
   );

   //############################################################
   // credit queue
   //############################################################

   erx_credit_queue u_queue
   (
      .rx_lclk     (rx_lclk),
      .rst_n       (rst_n),
      .pkt_valid   (pkt_valid),
      .pkt         (pkt),
      .out_credit  (out_credit),
      .link_credit (link_credit),
      .out_valid   (out_valid),
      .out_rx      (out_rx)
   );

endmodule

//--- tests/tb_erx_io.sv
`timescale 1ns/1ps
`include "erx_params.svh"

module tb_erx_io;

   localparam int          num_packets = 30;                      // 1 + 3 + 20 + 4 + 2
   localparam int          cycle_limit = 40 * num_packets + 200;
   localparam logic [31:0] seed        = 32'h6269_cf5c;

   logic               rx_lclk = 1'b0;
   logic               rst_n;
   erx_pkg::erx_lane_t lane;
   logic               out_credit = 1'b0;
   logic               link_credit;
   logic               out_valid;
   erx_pkg::erx_rx_t   out_rx;

   logic [31:0]        rng_state;                         // stimulus stream
   logic [31:0]        cons_rng = {seed[15:0], seed[31:16]};   // consumer stream
   logic [13:0][7:0]   prev_bytes;        // first packet of the current burst
   erx_pkg::erx_rx_t   exp_q [$];         // expected records in send order
   erx_pkg::erx_rx_t   exp_rec;
   int                 sent;              // one link credit per packet started
   int                 returned = 0;      // link_credit pulses
   int                 delivered = 0;
   int                 granted = 0;       // out_credit pulses
   int                 cycles = 0;
   int                 mark;
   logic               consumer_on;
   logic               grant_ok = 1'b0;   // negedge sample for the consumer
   logic               prev_link_credit = 1'b0;

   erx_io dut
   (
      .rx_lclk     (rx_lclk),
      .rst_n       (rst_n),
      .lane        (lane),
      .out_credit  (out_credit),
      .link_credit (link_credit),
      .out_valid   (out_valid),
      .out_rx      (out_rx)
   );

   always #4 rx_lclk = ~rx_lclk;    // 8 ns period

   //############################################################
   // reference model
   //############################################################

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // packet fields onto the 14 wire bytes
   function automatic logic [13:0][7:0] wire_image(input erx_pkg::erx_packet_t p,
                                                  input logic [7:0] b0);
      logic [13:0][7:0] w;
      w[0] = b0;                                   // never decoded
      w[1] = {p.ctrlmode, p.dstaddr[31:28]};
      w[2] = p.dstaddr[27:20];
      w[3] = p.dstaddr[19:12];
      w[4] = p.dstaddr[11:4];
      w[5] = {p.dstaddr[3:0], p.datamode, p.write, p.access};
      {w[6], w[7], w[8], w[9]}     = p.data;       // msb on byte 6
      {w[10], w[11], w[12], w[13]} = p.srcaddr;
      return w;
   endfunction

   // wire bytes back to a record
   // a burst continuation only carries bytes 6 to 13
   function automatic erx_pkg::erx_rx_t expected_rx(input logic [13:0][7:0] b,
                                                   input logic [13:0][7:0] prev,
                                                   input logic cont,
                                                   input logic frame_after);
      logic [13:0][7:0] s;
      erx_pkg::erx_rx_t r;
      s = b;
      if (cont)
         s[5:0] = prev[5:0];                       // halfwords 0 to 2 kept
      r.burst           = frame_after;
      r.packet.ctrlmode = s[1][7:4];
      r.packet.dstaddr  = {s[1][3:0], s[2], s[3], s[4], s[5][7:4]};
      r.packet.datamode = s[5][3:2];
      r.packet.write    = s[5][1];
      r.packet.access   = s[5][0];
      r.packet.data     = {s[6], s[7], s[8], s[9]};
      r.packet.srcaddr  = {s[10], s[11], s[12], s[13]};
      return r;
   endfunction

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "simulation stopped on first error");
   endtask

   //############################################################
   // transmitter
   //############################################################

   task automatic drive_word(input logic [1:0] frame, input logic [15:0] word);
      lane.frame = frame;
      lane.word  = word;
      @(posedge rx_lclk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_word(2'b00, 16'h0000);
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0)
         idle_cycles(1);
   endtask

   // n packets under one frame
   // a burst can't pause so all n credits come first
   task automatic send_burst(input int n);
      logic [127:0]         rnd;
      erx_pkg::erx_packet_t p;
      logic [13:0][7:0]     w;
      int                   first_hw;
      while (`ERX_QUEUE_DEPTH + returned - sent < n)
         idle_cycles(1);
      for (int i = 0; i < n; i++)
      begin
         for (int j = 0; j < 4; j++)
         begin
            rng_state = xorshift(rng_state);
            rnd       = {rnd[95:0], rng_state};
         end
         p = rnd[103:0];
         w = wire_image(p, rnd[111:104]);
         exp_q.push_back(expected_rx(w, prev_bytes, i > 0, i < n - 1));
         if (i == 0)
            prev_bytes = w;
         sent++;
         first_hw = (i == 0) ? 0 : 3;              // continuation restarts at halfword 3
         for (int k = first_hw; k < `ERX_HALFWORDS; k++)
            drive_word((i == 0 && k == 0) ? 2'b10 : 2'b11, {w[2*k+1], w[2*k]});
      end
   endtask

   //############################################################
   // checker, consumer, timeout
   //############################################################

   always @(negedge rx_lclk)
   begin
      if (rst_n)
      begin
         assert (out_valid == prev_link_credit)
         else report_error($sformatf("Mismatch at %0t: out_valid %b after link_credit %b",
                                     $time, out_valid, prev_link_credit));
         if (link_credit)
         begin
            assert (sent > returned)
            else report_error("link credit returned with no packet in flight");
            returned++;
         end
         if (out_valid)
         begin
            assert (exp_q.size() > 0)
            else report_error("record delivered although no packet was sent");
            exp_rec = exp_q.pop_front();
            assert (out_rx == exp_rec)
            else report_error($sformatf("Mismatch at %0t: record %0d got %h expected %h",
                                        $time, delivered, out_rx, exp_rec));
            delivered++;
         end
         grant_ok = consumer_on && (granted == 0 || granted - delivered < exp_q.size());
      end
      prev_link_credit = link_credit;
   end

   // random grants limited to the records still owed
   // the first grant lands on the idle link after reset
   always @(posedge rx_lclk)
   begin
      #1;
      cons_rng = xorshift(cons_rng);
      if (grant_ok && cons_rng[1:0] != 2'b00)
      begin
         out_credit = 1'b1;
         granted++;
      end
      else
         out_credit = 1'b0;
   end

   always @(posedge rx_lclk)
   begin
      cycles++;
      if (cycles > cycle_limit)
         report_error($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
   end

   //############################################################
   // test sequence
   //############################################################

   initial
   begin
      rng_state   = seed;
      lane        = '0;
      rst_n       = 1'b0;
      sent        = 0;
      consumer_on = 1'b1;
      prev_bytes  = '0;
      repeat (4) @(posedge rx_lclk);
      #1;
      rst_n = 1'b1;

      idle_cycles(20);                             // quiet link after reset
      assert (delivered == 0 && returned == 0)
      else report_error("output activity seen before any packet was sent");

      send_burst(1);
      wait_drain();
      send_burst(3);                               // burst flag on the first two
      wait_drain();

      // back to back with gaps of 0 to 3
      for (int i = 0; i < 20; i++)
      begin
         send_burst(1);
         rng_state = xorshift(rng_state);
         idle_cycles(int'(rng_state[1:0]));
      end
      wait_drain();

      // withhold consumer credits until the queue is full
      consumer_on = 1'b0;
      mark        = delivered;
      repeat (`ERX_QUEUE_DEPTH) send_burst(1);
      idle_cycles(30);
      assert (sent - returned == `ERX_QUEUE_DEPTH)
      else report_error("transmitter still held credits with the consumer stalled");
      assert (delivered == mark)
      else report_error("record delivered while consumer credits were withheld");
      consumer_on = 1'b1;
      send_burst(1);                               // waits for freed slots
      send_burst(1);
      wait_drain();

      assert (sent == num_packets && returned == delivered && delivered == sent)
      else report_error("link credit pulses do not match delivered records");
      $display("** PASS **");
      $finish;
   end

endmodule

//--- project.f
+incdir+src
src/erx_pkg.sv
src/erx_lane_sampler.sv
src/erx_packet_assembler.sv
src/erx_credit_queue.sv
src/erx_io.sv
tests/tb_erx_io.sv

//--- run.sh
#!/bin/sh
# build the erx_io testbench with verilator, run it, keep the output in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_erx_io -f project.f \
   && ./obj_dir/Vtb_erx_io | tee sim.log \
   || { echo "build or run failed"; exit 1; }
# the log decides the result
grep -q '\*\* FAIL \*\*' sim.log \
   && { echo "simulation failed"; exit 1; } \
   || echo "simulation passed"
